//--- hw/mips_mem_pkg.sv
package mips_mem_pkg;

    typedef logic [31:0] word_t;      // Data word or byte address
    typedef logic [3:0]  byte_en_t;   // Bit n enables lane n
    typedef logic [5:0]  opcode_t;    // MIPS primary opcode
    typedef logic [1:0]  byte_idx_t;  // Byte offset within a word

    typedef enum logic [1:0] {
        CLASS_OTHER  = 2'd0,
        CLASS_LOAD   = 2'd1,
        CLASS_STORE  = 2'd2,
        CLASS_BRANCH = 2'd3   // Handled like OTHER
    } instr_class_e;

    // Loads
    localparam opcode_t OP_LB  = 6'b100000;
    localparam opcode_t OP_LBU = 6'b100100;
    localparam opcode_t OP_LH  = 6'b100001;
    localparam opcode_t OP_LHU = 6'b100101;
    localparam opcode_t OP_LUI = 6'b001111;
    localparam opcode_t OP_LW  = 6'b100011;
    localparam opcode_t OP_LWL = 6'b100010;
    localparam opcode_t OP_LWR = 6'b100110;

    // Stores
    localparam opcode_t OP_SB  = 6'b101000;
    localparam opcode_t OP_SH  = 6'b101001;
    localparam opcode_t OP_SW  = 6'b101011;

    localparam int RAM_WORDS = 64;
    localparam int RAM_AW    = 6;    // Word index from address bits 7:2

endpackage

//--- hw/mem_bus_if.sv
interface mem_bus_if
    import mips_mem_pkg::*;
();

    word_t    addr;        // Word aligned
    byte_en_t byteenable;
    logic     write;
    word_t    writedata;
    word_t    readdata;

    modport master (
        output addr,
        output byteenable,
        output write,
        output writedata,
        input  readdata
    );

    modport slave (
        input  addr,
        input  byteenable,
        input  write,
        input  writedata,
        output readdata
    );

endinterface

//--- hw/mem_int.sv
module mem_int
    import mips_mem_pkg::*;
(
    input  word_t        cpu_out,
    input  opcode_t      op,
    input  instr_class_e instr_type,
    output word_t        mem_addr,
    output byte_en_t     byteenable
);

    byte_idx_t byte_idx;
    byte_en_t  half_en;
    logic      mem_class;

    assign byte_idx  = cpu_out[1:0];
    assign mem_addr  = {cpu_out[31:2], 2'b00};
    assign mem_class = (instr_type == CLASS_LOAD) || (instr_type == CLASS_STORE);

    // Halfword needs an even index
    always_comb begin
        case (byte_idx)
            2'd0:    half_en = 4'b0011;
            2'd2:    half_en = 4'b1100;
            default: half_en = 4'b0000;
        endcase
    end

    always_comb begin
        if (mem_class) begin
            case (op)
                OP_LB, OP_LBU, OP_SB: begin
                    byteenable = 4'b0001 << byte_idx;
                end
                OP_LH, OP_LHU, OP_SH: begin
                    byteenable = half_en;
                end
                OP_LW, OP_SW, OP_LUI: begin
                    byteenable = 4'b1111;
                end
                OP_LWL: begin
                    byteenable = 4'b1111 << byte_idx;          // Index up to lane 3
                end
                OP_LWR: begin
                    byteenable = 4'b1111 >> (2'd3 - byte_idx); // Lane 0 up to index
                end
                default: begin
                    byteenable = 4'b0000;
                end
            endcase
        end else begin
            byteenable = 4'b1111;
        end
    end

endmodule

//--- hw/store_align.sv
module store_align
    import mips_mem_pkg::*;
(
    input  logic         req,
    input  instr_class_e instr_type,
    input  opcode_t      op,
    input  word_t        rt_val,
    mem_bus_if.master    bus
);

    assign bus.write = req && (instr_type == CLASS_STORE);

    // Copy onto every lane, byte enables pick what lands
    always_comb begin
        case (op)
            OP_SB: begin
                bus.writedata = {4{rt_val[7:0]}};
            end
            OP_SH: begin
                bus.writedata = {2{rt_val[15:0]}};
            end
            default: begin
                bus.writedata = rt_val;
            end
        endcase
    end

endmodule

//--- hw/load_extend.sv
module load_extend
    import mips_mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         req,
    input  instr_class_e instr_type,
    input  opcode_t      op,
    input  byte_idx_t    byte_idx,
    input  word_t        rt_val,
    mem_bus_if.master    bus,
    output word_t        load_result,
    output logic         load_valid
);

    logic        load_req;
    logic        pend_q;
    opcode_t     op_q;
    byte_idx_t   idx_q;
    byte_en_t    be_q;
    word_t       rt_q;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    word_t       merged;
    word_t       result;

    assign load_req = req && (instr_type == CLASS_LOAD);

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= load_req;
        end
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            op_q  <= op;
            idx_q <= byte_idx;
            be_q  <= bus.byteenable;
            rt_q  <= rt_val;
        end
    end

    assign sel_byte = bus.readdata[8*idx_q +: 8];
    assign sel_half = idx_q[1] ? bus.readdata[31:16] : bus.readdata[15:0];

    // LWL/LWR keep rt in the lanes not fetched
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = be_q[i] ? bus.readdata[8*i +: 8] : rt_q[8*i +: 8];
        end
    end

    always_comb begin
        case (op_q)
            OP_LB:          result = {{24{sel_byte[7]}}, sel_byte};
            OP_LBU:         result = {24'h0, sel_byte};
            OP_LH:          result = idx_q[0] ? '0 : {{16{sel_half[15]}}, sel_half};
            OP_LHU:         result = idx_q[0] ? '0 : {16'h0, sel_half};
            OP_LW:          result = bus.readdata;
            OP_LWL, OP_LWR: result = merged;
            default:        result = '0;  // LUI value comes from the ALU
        endcase
    end

    assign load_valid  = pend_q;
    assign load_result = pend_q ? result : '0;

    // Byte loads read the one lane that was enabled
    a_byte_lane_enabled: assert property (@(posedge clk) disable iff (rst)
        (load_valid && (op_q == OP_LB || op_q == OP_LBU)) |-> $onehot(be_q) && be_q[idx_q]);

endmodule

//--- hw/data_ram.sv
module data_ram
    import mips_mem_pkg::*;
(
    input logic      clk,
    mem_bus_if.slave bus,
    input logic      req
);

    word_t             mem [RAM_WORDS];
    logic [RAM_AW-1:0] widx;

    assign widx = bus.addr[RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (req && bus.write) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.byteenable[i]) begin
                    mem[widx][8*i +: 8] <= bus.writedata[8*i +: 8];
                end
            end
        end
    end

    // Old word on a store cycle, new word from the next request on
    always_ff @(posedge clk) begin
        if (req) begin
            bus.readdata <= mem[widx];
        end
    end

    a_addr_in_range: assert property (@(posedge clk)
        req |-> (bus.addr[1:0] == 2'b00) && (bus.addr[31:RAM_AW+2] == '0));

endmodule

//--- hw/lsu_top.sv
module lsu_top
    import mips_mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         req,
    input  word_t        addr_in,
    input  opcode_t      op,
    input  instr_class_e instr_class,
    input  word_t        rt_val,
    output word_t        mem_addr,
    output byte_en_t     byteenable,
    output word_t        load_result,
    output logic         load_valid
);

    mem_bus_if bus ();

    mem_int u_mem_int (
        .cpu_out    (addr_in),
        .op         (op),
        .instr_type (instr_class),
        .mem_addr   (bus.addr),
        .byteenable (bus.byteenable)
    );

    store_align u_store_align (
        .req        (req),
        .instr_type (instr_class),
        .op         (op),
        .rt_val     (rt_val),
        .bus        (bus.master)
    );

    load_extend u_load_extend (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .instr_type  (instr_class),
        .op          (op),
        .byte_idx    (addr_in[1:0]),
        .rt_val      (rt_val),
        .bus         (bus.master),
        .load_result (load_result),
        .load_valid  (load_valid)
    );

    data_ram u_data_ram (
        .clk (clk),
        .bus (bus.slave),
        .req (req)
    );

    assign mem_addr   = bus.addr;
    assign byteenable = bus.byteenable;

endmodule

//--- verif/lsu_tb.sv
module lsu_tb
    import mips_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        opcode_t      op;
        instr_class_e cls;
        word_t        addr;
        word_t        rt;
        word_t        exp_addr;
        byte_en_t     exp_be;
        logic         exp_valid;
        word_t        exp_result;
    } test_row_t;

    logic         clk;
    logic         rst;
    logic         req;
    word_t        addr_in;
    opcode_t      op;
    instr_class_e instr_class;
    word_t        rt_val;
    word_t        mem_addr;
    byte_en_t     byteenable;
    word_t        load_result;
    logic         load_valid;

    test_row_t rows [$];
    word_t     shadow [RAM_WORDS];   // Expected RAM contents
    word_t     rng = 32'd87482;
    int        errors;
    int        checks;
    int        row_errors;
    int        cycles;
    int        cycle_limit = 1000;   // Replaced once the table is built

    lsu_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .addr_in     (addr_in),
        .op          (op),
        .instr_class (instr_class),
        .rt_val      (rt_val),
        .mem_addr    (mem_addr),
        .byteenable  (byteenable),
        .load_result (load_result),
        .load_valid  (load_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run stopped by timeout after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic word_t xorshift(word_t s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Lane enables as the byte-enable rules describe them
    function automatic byte_en_t lane_rule(opcode_t o, instr_class_e c, int ix);
        byte_en_t be;
        be = '0;
        if (c != CLASS_LOAD && c != CLASS_STORE) begin
            return 4'b1111;
        end
        for (int i = 0; i < 4; i++) begin
            case (o)
                OP_LB, OP_LBU, OP_SB: be[i] = (i == ix);
                OP_LH, OP_LHU, OP_SH: be[i] = (ix % 2 == 0) && (i / 2 == ix / 2);
                OP_LW, OP_SW, OP_LUI: be[i] = 1'b1;
                OP_LWL:               be[i] = (i >= ix);
                OP_LWR:               be[i] = (i <= ix);
                default:              be[i] = 1'b0;
            endcase
        end
        return be;
    endfunction

    function automatic logic [7:0] store_lane(opcode_t o, word_t rt, int i);
        case (o)
            OP_SB:   return rt[7:0];
            OP_SH:   return 8'(rt >> (8 * (i % 2)));
            default: return 8'(rt >> (8 * i));
        endcase
    endfunction

    function automatic word_t expect_load(opcode_t o, int ix, word_t w, word_t rt,
                                          byte_en_t be);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       mask;
        b = 8'(w >> (8 * ix));
        h = 16'(w >> (8 * ix));
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        case (o)
            OP_LB:          return {{24{b[7]}}, b};
            OP_LBU:         return {24'h0, b};
            OP_LH:          return (ix % 2 != 0) ? '0 : {{16{h[15]}}, h};
            OP_LHU:         return (ix % 2 != 0) ? '0 : {16'h0, h};
            OP_LW:          return w;
            OP_LWL, OP_LWR: return (w & mask) | (rt & ~mask);
            default:        return '0;
        endcase
    endfunction

    // Works out the expected response and updates the shadow RAM
    task automatic add_row(opcode_t o, instr_class_e c, word_t a, word_t rt);
        test_row_t r;
        int        wi;
        int        ix;
        wi = int'(a[7:2]);
        ix = int'(a[1:0]);
        r.op         = o;
        r.cls        = c;
        r.addr       = a;
        r.rt         = rt;
        r.exp_addr   = {a[31:2], 2'b00};
        r.exp_be     = lane_rule(o, c, ix);
        r.exp_valid  = (c == CLASS_LOAD);
        r.exp_result = '0;
        if (c == CLASS_LOAD) begin
            r.exp_result = expect_load(o, ix, shadow[wi], rt, r.exp_be);
        end
        if (c == CLASS_STORE) begin
            for (int i = 0; i < 4; i++) begin
                if (r.exp_be[i]) begin
                    shadow[wi][8*i +: 8] = store_lane(o, rt, i);
                end
            end
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        opcode_t ext_ops [4];
        ext_ops[0] = OP_LB;
        ext_ops[1] = OP_LBU;
        ext_ops[2] = OP_LH;
        ext_ops[3] = OP_LHU;
        // SW then LW of four words, every byte index used once each
        for (int k = 0; k < 4; k++) begin
            add_row(OP_SW, CLASS_STORE, word_t'(32'h40 + 5 * k), next_rand());
            add_row(OP_LW, CLASS_LOAD, word_t'(32'h40 + 4 * k + (3 - k)), next_rand());
        end
        for (int k = 0; k < 4; k++) begin
            add_row(OP_SB, CLASS_STORE, word_t'(32'h40 + k), next_rand());
        end
        add_row(OP_LW, CLASS_LOAD, 32'h40, next_rand());
        for (int k = 0; k < 4; k++) begin
            add_row(OP_SH, CLASS_STORE, word_t'(32'h44 + k), next_rand());  // 1 and 3 misaligned
        end
        add_row(OP_LW, CLASS_LOAD, 32'h44, next_rand());
        // Non-memory classes must leave word 0x48 alone
        add_row(OP_SW, CLASS_OTHER, 32'h49, next_rand());
        add_row(OP_SB, CLASS_OTHER, 32'h4a, next_rand());
        add_row(OP_LW, CLASS_BRANCH, 32'h4b, next_rand());
        add_row(OP_LW, CLASS_LOAD, 32'h48, next_rand());
        // Lanes of both signs for extension checks
        add_row(OP_SW, CLASS_STORE, 32'h4c, 32'h3c9a_f015);
        for (int j = 0; j < 4; j++) begin
            for (int k = 0; k < 4; k++) begin
                add_row(ext_ops[j], CLASS_LOAD, word_t'(32'h4c + k), next_rand());
            end
        end
        for (int k = 0; k < 4; k++) begin
            add_row(OP_LWL, CLASS_LOAD, word_t'(32'h40 + k), next_rand());
            add_row(OP_LWR, CLASS_LOAD, word_t'(32'h40 + k), next_rand());
        end
        for (int k = 0; k < 4; k++) begin
            add_row(OP_LUI, CLASS_LOAD, word_t'(32'h50 + k), next_rand());
        end
    endtask

    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            errors++;
            row_errors++;
        end
    endtask

    task automatic apply_row(int n);
        test_row_t r;
        r = rows[n];
        row_errors = 0;
        @(negedge clk);
        check_value("load_valid", word_t'(load_valid), '0);  // Pulse from last row is over
        req         = 1'b1;
        addr_in     = r.addr;
        op          = r.op;
        instr_class = r.cls;
        rt_val      = r.rt;
        #1;
        check_value("mem_addr", mem_addr, r.exp_addr);
        check_value("byteenable", word_t'(byteenable), word_t'(r.exp_be));
        @(negedge clk);
        req = 1'b0;
        check_value("load_valid", word_t'(load_valid), word_t'(r.exp_valid));
        if (r.exp_valid) begin
            check_value("load_result", load_result, r.exp_result);
        end
        $display("row %0d op %h class %0d addr %h: %s", n, r.op, r.cls, r.addr,
                 (row_errors == 0) ? "pass" : "mismatch");
    endtask

    initial begin
        rst         = 1'b1;
        req         = 1'b0;
        addr_in     = '0;
        op          = '0;
        instr_class = CLASS_OTHER;
        rt_val      = '0;
        build_table();
        cycle_limit = 2 * rows.size() * 2 + 10 + 50;
        row_errors  = 0;
        repeat (10) begin
            @(negedge clk);
            check_value("load_valid", word_t'(load_valid), '0);
        end
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_value("load_valid", word_t'(load_valid), '0);
            check_value("load_result", load_result, '0);
        end
        $display("reset: %s", (row_errors == 0) ? "pass" : "mismatch");
        for (int n = 0; n < rows.size(); n++) begin
            apply_row(n);
        end
        @(negedge clk);
        check_value("load_valid", word_t'(load_valid), '0);  // Last pulse has ended
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
hw/mips_mem_pkg.sv
hw/mem_bus_if.sv
hw/mem_int.sv
hw/store_align.sv
hw/load_extend.sv
hw/data_ram.sv
hw/lsu_top.sv
verif/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the load/store subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module lsu_tb \
    -f sources.f \
    -Mdir obj_dir \
    -o lsu_sim

./obj_dir/lsu_sim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
